// ==== kiwi_backend.f ====
verilog/kiwi_pkg.sv
verilog/operand_read.sv
verilog/alu_lane.sv
verilog/write_back.sv
verilog/kiwi_backend.sv
tests/tb_clock.sv
tests/kiwi_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module kiwi_backend_tb \
	-f kiwi_backend.f -o kiwi_backend_sim || exit 1

result=$(./obj_dir/kiwi_backend_sim 2>&1)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx 'Done: no errors' && exit 0 || exit 1

// ==== tests/kiwi_backend_vectors.txt ====
// slot0, slot1 issue: valid sid func rs1 rs2 use_imm imm rd rd_valid
// lane0, lane1 expected retire: valid sid rd rd_valid value (all hex)
0 0 0 00 00 0 000 00 0  0 0 0 00 00 0 000 00 0  0 0 00 0 0  0 0 00 0 0
// seed registers from immediates
1 2 0 00 00 1 7ff 01 1  1 3 0 00 00 1 800 02 1  1 2 01 1 7ff  1 3 02 1 fffffffffffff800
1 4 0 00 00 1 123 03 1  1 5 0 00 00 1 ffd 04 1  1 4 03 1 123  1 5 04 1 fffffffffffffffd
// each function code, register and immediate forms
1 6 1 01 02 0 000 05 1  1 7 2 01 00 1 0f0 06 1  1 6 05 1 fff  1 7 06 1 f0
1 8 3 03 00 1 400 07 1  1 9 4 04 01 0 000 08 1  1 8 07 1 523  1 9 08 1 fffffffffffff802
1 a 5 05 00 1 004 09 1  1 b 6 02 00 1 03c 0a 1  1 a 09 1 fff0  1 b 0a 1 f
1 c 7 02 00 1 008 0b 1  1 d 7 08 06 0 000 0c 1  1 c 0b 1 fffffffffffffff8  1 d 0c 1 ffffffffffffffff
1 e 8 02 01 0 000 0d 1  1 f 9 02 01 0 000 0e 1  1 e 0d 1 1  1 f 0e 1 0
1 0 8 01 00 1 fff 0f 1  1 1 9 01 00 1 fff 10 1  1 0 0f 1 0  1 1 10 1 1
1 2 1 09 00 1 ff0 11 1  1 3 2 04 00 1 ff0 12 1  1 2 11 1 10000  1 3 12 1 fffffffffffffff0
1 4 3 03 0a 0 000 13 1  1 5 4 01 00 1 800 14 1  1 4 13 1 12f  1 5 14 1 ffffffffffffffff
1 6 5 01 0a 0 000 15 1  1 7 6 0b 03 0 000 16 1  1 6 15 1 3ff8000  1 7 16 1 1fffffff
// unknown function codes
1 8 a 01 00 1 7ff 17 1  1 9 f 01 02 0 000 18 1  1 8 17 1 0  1 9 18 1 0
1 a 0 05 02 0 000 19 1  1 b 2 08 03 0 000 1a 1  1 a 19 1 7ff  1 b 1a 1 2
// producers, then consumers two and more cycles later
1 c 0 00 00 1 055 1b 1  1 d 0 00 00 1 7a0 1c 1  1 c 1b 1 55  1 d 1c 1 7a0
1 e 0 19 1a 0 000 1d 1  0 0 0 00 00 0 000 00 0  1 e 1d 1 801  0 0 00 0 0
1 0 0 1b 1c 0 000 1d 1  1 1 0 19 00 1 001 1f 1  1 0 1d 1 7f5  1 1 1f 1 800
0 0 0 00 00 0 000 00 0  0 0 0 00 00 0 000 00 0  0 0 00 0 0  0 0 00 0 0
1 4 0 1d 00 0 000 17 1  1 5 0 1f 1b 0 000 18 1  1 4 17 1 7f5  1 5 18 1 855
// writes to x0 retire, x0 still reads zero
1 6 0 00 00 1 3ab 00 1  1 7 0 01 00 1 001 00 1  1 6 00 1 3ab  1 7 00 1 800
0 0 0 00 00 0 000 00 0  0 0 0 00 00 0 000 00 0  0 0 00 0 0  0 0 00 0 0
1 a 0 00 01 0 000 1b 1  1 b 4 01 00 0 000 1c 1  1 a 1b 1 7ff  1 b 1c 1 7ff
// same rd from both slots, slot 1 wins
1 c 0 00 00 1 111 14 1  1 d 0 00 00 1 222 14 1  1 c 14 1 111  1 d 14 1 222
0 0 0 00 00 0 000 00 0  0 0 0 00 00 0 000 00 0  0 0 00 0 0  0 0 00 0 0
1 0 0 14 00 0 000 15 1  1 1 4 14 00 1 333 16 1  1 0 15 1 222  1 1 16 1 111
// both slots full every cycle
1 2 0 01 00 1 001 0a 1  1 3 1 01 03 0 000 0b 1  1 2 0a 1 800  1 3 0b 1 6dc
1 4 0 03 03 0 000 0c 1  1 5 4 01 03 0 000 0d 1  1 4 0c 1 246  1 5 0d 1 6dc
1 6 0 0a 0b 0 000 0e 1  1 7 5 03 00 1 008 0f 1  1 6 0e 1 edc  1 7 0f 1 12300
1 8 1 0c 0d 0 000 10 1  1 9 3 01 00 1 800 11 1  1 8 10 1 fffffffffffffb6a  1 9 11 1 ffffffffffffffff
1 a 0 0e 0f 0 000 12 1  1 b 9 03 01 0 000 13 1  1 a 12 1 131dc  1 b 13 1 1
1 c 7 10 00 1 004 0a 1  1 d 2 11 01 0 000 0b 1  1 c 0a 1 ffffffffffffffb6  1 d 0b 1 7ff
1 e 0 01 00 1 001 01 0  1 f 1 03 00 1 003 05 0  1 e 01 0 800  1 f 05 0 120

// ==== tests/kiwi_backend_tb.sv ====
`timescale 1ns/1ns

module kiwi_backend_tb;

	import kiwi_pkg::*;

	localparam int ISSUE_WIDTH    = 2;
	localparam int NUM_ROWS       = 32;
	localparam int SLOT_FIELDS    = 9;
	localparam int RESULT_FIELDS  = 5;
	localparam int ROW_FIELDS     = ISSUE_WIDTH * (SLOT_FIELDS + RESULT_FIELDS);
	localparam int LATENCY        = 3;
	localparam int TIMEOUT_CYCLES = NUM_ROWS + 10;

	logic clk;
	logic rst_n;

	issue_t       [ISSUE_WIDTH-1:0] issue;
	lane_result_t [ISSUE_WIDTH-1:0] retire;

	// one hex field per word, ROW_FIELDS words per cycle
	logic [63:0] vectors [NUM_ROWS * ROW_FIELDS];

	int error_count = 0;
	int cycle_count = 0;

	tb_clock clock_i (
		.clk_o(clk),
		.rst_n_o(rst_n)
	);

	kiwi_backend #(
		.ISSUE_WIDTH(ISSUE_WIDTH)
	) kiwi_backend_i (
		.clk(clk),
		.rst_n_i(rst_n),
		.issue_i(issue),
		.retire_o(retire)
	);

	function automatic issue_t issue_from_row(input int row, input int slot);
		issue_t op;
		int     base;
		base = row * ROW_FIELDS + slot * SLOT_FIELDS;
		op.valid    = vectors[base][0];
		op.sid      = vectors[base + 1][3:0];
		op.func     = vectors[base + 2][3:0];
		op.rs1      = vectors[base + 3][4:0];
		op.rs2      = vectors[base + 4][4:0];
		op.use_imm  = vectors[base + 5][0];
		op.imm      = vectors[base + 6][11:0];
		op.rd       = vectors[base + 7][4:0];
		op.rd_valid = vectors[base + 8][0];
		return op;
	endfunction

	// expected columns follow both issue slots
	function automatic lane_result_t expected_from_row(input int row, input int lane);
		lane_result_t res;
		int           base;
		base = row * ROW_FIELDS + ISSUE_WIDTH * SLOT_FIELDS + lane * RESULT_FIELDS;
		res.valid    = vectors[base][0];
		res.sid      = vectors[base + 1][3:0];
		res.rd       = vectors[base + 2][4:0];
		res.rd_valid = vectors[base + 3][0];
		res.value    = vectors[base + 4];
		return res;
	endfunction

	task automatic drive_row(input int row);
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			issue[k] <= issue_from_row(row, k);
		end
	endtask

	task automatic check_value(input string field, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("FAIL %0t: %s got %h expected %h", $time, field, got, expected);
			error_count++;
		end
	endtask

	// payload only matters for a valid retire
	task automatic check_retire(input int row);
		lane_result_t exp_res;
		string        where;
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			exp_res = expected_from_row(row, k);
			where   = $sformatf("row %0d lane %0d", row, k);
			check_value({where, " valid"}, 64'(retire[k].valid), 64'(exp_res.valid));
			if (exp_res.valid) begin
				check_value({where, " sid"}, 64'(retire[k].sid), 64'(exp_res.sid));
				check_value({where, " rd"}, 64'(retire[k].rd), 64'(exp_res.rd));
				check_value({where, " rd_valid"}, 64'(retire[k].rd_valid),
					64'(exp_res.rd_valid));
				check_value({where, " value"}, retire[k].value, exp_res.value);
			end
		end
	endtask

	task automatic finish_run();
		$display("errors counted: %0d", error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		error_count++;
		finish_run();
	end

	initial begin
		issue = '0;
		$readmemh("tests/kiwi_backend_vectors.txt", vectors);
		wait (rst_n === 1'b1);
		// row i is driven at edge i and retires three edges later
		for (int i = 0; i < NUM_ROWS + LATENCY; i++) begin
			@(posedge clk);
			if (i < NUM_ROWS) begin
				drive_row(i);
			end else begin
				issue <= '0;
			end
			@(negedge clk);
			if (i >= LATENCY) begin
				check_retire(i - LATENCY);
			end else begin
				for (int k = 0; k < ISSUE_WIDTH; k++) begin
					check_value($sformatf("idle lane %0d valid", k),
						64'(retire[k].valid), 64'd0);
				end
			end
		end
		finish_run();
	end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// release lands after the flops have sampled the edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== verilog/kiwi_backend.sv ====
`timescale 1ns/1ns

module kiwi_backend #(
	parameter int ISSUE_WIDTH = 2
) (
	input  logic                                      clk,
	input  logic                                      rst_n_i,
	input  kiwi_pkg::issue_t       [ISSUE_WIDTH-1:0] issue_i,
	output kiwi_pkg::lane_result_t [ISSUE_WIDTH-1:0] retire_o
);

	import kiwi_pkg::*;

	exe_op_t      [ISSUE_WIDTH-1:0] exe_op;
	lane_result_t [ISSUE_WIDTH-1:0] lane_result;
	reg_write_t   [ISSUE_WIDTH-1:0] reg_write;

	// register read, operands registered per lane
	operand_read #(
		.ISSUE_WIDTH(ISSUE_WIDTH)
	) operand_read_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.issue_i(issue_i),
		.reg_write_i(reg_write),
		.exe_op_o(exe_op)
	);

	// one lane per issue slot
	genvar k;
	generate
		for (k = 0; k < ISSUE_WIDTH; k++) begin : g_lane
			alu_lane alu_lane_i (
				.clk(clk),
				.rst_n_i(rst_n_i),
				.exe_op_i(exe_op[k]),
				.result_o(lane_result[k])
			);
		end
	endgenerate

	// regfile update and retire
	write_back #(
		.ISSUE_WIDTH(ISSUE_WIDTH)
	) write_back_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.lane_result_i(lane_result),
		.reg_write_o(reg_write),
		.retire_o(retire_o)
	);

endmodule

// ==== verilog/write_back.sv ====
`timescale 1ns/1ns

module write_back #(
	parameter int ISSUE_WIDTH = 2
) (
	input  logic                                      clk,
	input  logic                                      rst_n_i,
	input  kiwi_pkg::lane_result_t [ISSUE_WIDTH-1:0] lane_result_i,
	output kiwi_pkg::reg_write_t   [ISSUE_WIDTH-1:0] reg_write_o,
	output kiwi_pkg::lane_result_t [ISSUE_WIDTH-1:0] retire_o
);

	import kiwi_pkg::*;

	logic         [ISSUE_WIDTH-1:0] wants_write;
	logic         [ISSUE_WIDTH-1:0] overridden;
	logic         [ISSUE_WIDTH-1:0] retire_valid_q;
	lane_result_t [ISSUE_WIDTH-1:0] retire_q;

	always_comb begin
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			wants_write[k] = lane_result_i[k].valid && lane_result_i[k].rd_valid &&
				lane_result_i[k].rd != '0;
		end
	end

	// higher lane is younger, so it owns a shared rd
	always_comb begin
		overridden = '0;
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			for (int j = k + 1; j < ISSUE_WIDTH; j++) begin
				if (wants_write[j] && lane_result_i[j].rd == lane_result_i[k].rd) begin
					overridden[k] = 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			reg_write_o[k].en    = wants_write[k] && !overridden[k];
			reg_write_o[k].rd    = lane_result_i[k].rd;
			reg_write_o[k].value = lane_result_i[k].value;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			retire_valid_q <= '0;
		end else begin
			for (int k = 0; k < ISSUE_WIDTH; k++) begin
				retire_valid_q[k] <= lane_result_i[k].valid;
			end
		end
	end

	// every lane retires, even an overridden one
	always_ff @(posedge clk) begin
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			if (lane_result_i[k].valid) begin
				retire_q[k] <= lane_result_i[k];
			end
		end
	end

	always_comb begin
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			retire_o[k]       = retire_q[k];
			retire_o[k].valid = retire_valid_q[k];
		end
	end

	// sids tag ops end to end, so lanes in one group never share one
	for (genvar a = 0; a < ISSUE_WIDTH; a++) begin : g_sid_a
		for (genvar b = a + 1; b < ISSUE_WIDTH; b++) begin : g_sid_b
			a_sid_unique: assert property (@(posedge clk) disable iff (!rst_n_i)
				lane_result_i[a].valid && lane_result_i[b].valid |->
					lane_result_i[a].sid != lane_result_i[b].sid);
		end
	end

endmodule

// ==== verilog/alu_lane.sv ====
`timescale 1ns/1ns

module alu_lane (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  kiwi_pkg::exe_op_t      exe_op_i,
	output kiwi_pkg::lane_result_t result_o
);

	import kiwi_pkg::*;

	xlen_t        op_a;
	xlen_t        op_b;
	xlen_t        imm_ext;
	logic [5:0]   shamt;
	xlen_t        alu_out;
	logic         valid_q;
	lane_result_t result_q;

	// sign extend the 12 bit immediate
	assign imm_ext = {{(XLEN - $bits(imm_t)){exe_op_i.imm[$bits(imm_t)-1]}}, exe_op_i.imm};

	assign op_a  = exe_op_i.rs1_value;
	assign op_b  = exe_op_i.use_imm ? imm_ext : exe_op_i.rs2_value;
	assign shamt = op_b[5:0];

	always_comb begin
		case (exe_op_i.func)
			FUNC_ADD: begin
				alu_out = op_a + op_b;
			end
			FUNC_SUB: begin
				alu_out = op_a - op_b;
			end
			FUNC_AND: begin
				alu_out = op_a & op_b;
			end
			FUNC_OR: begin
				alu_out = op_a | op_b;
			end
			FUNC_XOR: begin
				alu_out = op_a ^ op_b;
			end
			FUNC_SLL: begin
				alu_out = op_a << shamt;
			end
			FUNC_SRL: begin
				alu_out = op_a >> shamt;
			end
			FUNC_SRA: begin
				alu_out = $unsigned($signed(op_a) >>> shamt);
			end
			FUNC_SLT: begin
				alu_out = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			end
			FUNC_SLTU: begin
				alu_out = {{(XLEN-1){1'b0}}, (op_a < op_b)};
			end
			// unknown codes
			default: begin
				alu_out = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= exe_op_i.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (exe_op_i.valid) begin
			result_q.valid    <= 1'b1;
			result_q.sid      <= exe_op_i.sid;
			result_q.rd       <= exe_op_i.rd;
			result_q.rd_valid <= exe_op_i.rd_valid;
			result_q.value    <= alu_out;
		end
	end

	always_comb begin
		result_o       = result_q;
		result_o.valid = valid_q;
	end

	// operand stage must never hand over an X valid
	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(exe_op_i.valid));

endmodule

// ==== verilog/operand_read.sv ====
`timescale 1ns/1ns

module operand_read #(
	parameter int ISSUE_WIDTH = 2
) (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  kiwi_pkg::issue_t     [ISSUE_WIDTH-1:0] issue_i,
	input  kiwi_pkg::reg_write_t [ISSUE_WIDTH-1:0] reg_write_i,
	output kiwi_pkg::exe_op_t    [ISSUE_WIDTH-1:0] exe_op_o
);

	import kiwi_pkg::*;

	xlen_t regfile [32];
	// cleared on reset so untouched registers read as zero
	logic [31:0] reg_written;

	exe_op_t [ISSUE_WIDTH-1:0] op_d;
	exe_op_t [ISSUE_WIDTH-1:0] op_q;
	logic    [ISSUE_WIDTH-1:0] valid_q;

	// x0 is hardwired, same-cycle writes bypass the array
	function automatic xlen_t read_reg(input reg_idx_t idx);
		xlen_t value;
		value = reg_written[idx] ? regfile[idx] : '0;
		// later ports take priority
		for (int w = 0; w < ISSUE_WIDTH; w++) begin
			if (reg_write_i[w].en && reg_write_i[w].rd == idx) begin
				value = reg_write_i[w].value;
			end
		end
		if (idx == '0) begin
			value = '0;
		end
		return value;
	endfunction

	always_ff @(posedge clk) begin
		for (int w = 0; w < ISSUE_WIDTH; w++) begin
			if (reg_write_i[w].en) begin
				regfile[reg_write_i[w].rd] <= reg_write_i[w].value;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			reg_written <= '0;
		end else begin
			for (int w = 0; w < ISSUE_WIDTH; w++) begin
				if (reg_write_i[w].en) begin
					reg_written[reg_write_i[w].rd] <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			op_d[k].valid     = issue_i[k].valid;
			op_d[k].sid       = issue_i[k].sid;
			op_d[k].func      = issue_i[k].func;
			op_d[k].use_imm   = issue_i[k].use_imm;
			op_d[k].imm       = issue_i[k].imm;
			op_d[k].rd        = issue_i[k].rd;
			op_d[k].rd_valid  = issue_i[k].rd_valid;
			op_d[k].rs1_value = read_reg(issue_i[k].rs1);
			op_d[k].rs2_value = read_reg(issue_i[k].rs2);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else begin
			for (int k = 0; k < ISSUE_WIDTH; k++) begin
				valid_q[k] <= issue_i[k].valid;
			end
		end
	end

	// payload only moves with a valid op
	always_ff @(posedge clk) begin
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			if (issue_i[k].valid) begin
				op_q[k] <= op_d[k];
			end
		end
	end

	always_comb begin
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			exe_op_o[k]       = op_q[k];
			exe_op_o[k].valid = valid_q[k];
		end
	end

	// write_back must filter x0 before it gets here
	for (genvar w = 0; w < ISSUE_WIDTH; w++) begin : g_wr_chk
		a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
			reg_write_i[w].en |-> reg_write_i[w].rd != '0);
	end

endmodule

// ==== verilog/kiwi_pkg.sv ====
package kiwi_pkg;

	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [3:0]      sid_t;
	typedef logic [11:0]     imm_t;
	typedef logic [3:0]      func_t;

	// alu function codes, anything above 9 yields zero
	localparam func_t FUNC_ADD  = 4'd0;
	localparam func_t FUNC_SUB  = 4'd1;
	localparam func_t FUNC_AND  = 4'd2;
	localparam func_t FUNC_OR   = 4'd3;
	localparam func_t FUNC_XOR  = 4'd4;
	localparam func_t FUNC_SLL  = 4'd5;
	localparam func_t FUNC_SRL  = 4'd6;
	localparam func_t FUNC_SRA  = 4'd7;
	localparam func_t FUNC_SLT  = 4'd8;
	localparam func_t FUNC_SLTU = 4'd9;

	typedef struct packed {
		logic     valid;
		sid_t     sid;
		func_t    func;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic     use_imm;
		imm_t     imm;
		reg_idx_t rd;
		logic     rd_valid;
	} issue_t;

	typedef struct packed {
		logic     valid;
		sid_t     sid;
		func_t    func;
		logic     use_imm;
		imm_t     imm;
		reg_idx_t rd;
		logic     rd_valid;
		xlen_t    rs1_value;
		xlen_t    rs2_value;
	} exe_op_t;

	typedef struct packed {
		logic     valid;
		sid_t     sid;
		reg_idx_t rd;
		logic     rd_valid;
		xlen_t    value;
	} lane_result_t;

	typedef struct packed {
		logic     en;
		reg_idx_t rd;
		xlen_t    value;
	} reg_write_t;

endpackage
